// ==== src/mem_store_pkg.sv ====
`default_nettype none

package mem_store_pkg;

    // ********************
    // Geometry of the record store
    // ********************

    // Address width for the 2048 entry array
    localparam int ADDR_W = 11;
    localparam int DEPTH  = 2048;

    // One record is 64 bits, protected by one parity bit per 32-bit half
    localparam int DATA_W = 64;
    localparam int PAR_W  = 2;
    localparam int HALF_W = DATA_W / PAR_W;

    // Stored word keeps parity in the top bits and the record below it
    localparam int WORD_W = DATA_W + PAR_W;

    // ********************
    // Request and response records
    // ********************

    // Registered request from the input side into the SRAM wrapper
    typedef struct packed {
        logic              we;
        logic              re;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] word;
    } mem_req_t;

    // Read response handed back to the client
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              par_err;
    } rd_rsp_t;

    // Even parity of each half, bit 0 covers the low half
    function automatic logic [PAR_W-1:0] calc_par(input logic [DATA_W-1:0] d);
        logic [PAR_W-1:0] p;
        for (int i = 0; i < PAR_W; i++) begin
            p[i] = ^d[i*HALF_W +: HALF_W];
        end
        return p;
    endfunction

endpackage

`default_nettype wire

// ==== src/mem_req_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_req_ctrl (
     input  logic                           clk
    ,input  logic                           rst_n
    ,input  logic                           wr
    ,input  logic                           rd
    ,input  logic [mem_store_pkg::ADDR_W-1:0] addr
    ,input  logic [mem_store_pkg::DATA_W-1:0] wdata
    ,input  logic                           par_inject
    ,input  logic                           isol_en
    ,input  logic                           pwr_enable_b_out
    ,output mem_store_pkg::mem_req_t        req
    ,output logic                           access_err
);

    import mem_store_pkg::*;

    // ********************
    // Request screening
    // ********************

    logic              access_ok;
    logic              any_req;
    logic              drop_req;
    logic [PAR_W-1:0]  wr_par;

    // Registered request fields
    logic              we_q;
    logic              re_q;
    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] word_q;

    // The array is usable only when powered up and not isolated
    assign access_ok = !pwr_enable_b_out && !isol_en;
    assign any_req   = wr || rd;

    // A request is dropped when the array is unusable, or when a read
    // collides with a write. In the collision case only the read is lost
    assign drop_req  = any_req && (!access_ok || (wr && rd));

    // Parity for the write word, flipped on both halves when injecting a fault
    assign wr_par    = calc_par(wdata) ^ {PAR_W{par_inject}};

    // ********************
    // Request register
    // ********************

    // Strobes and the error pulse live for exactly one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q       <= 1'b0;
            re_q       <= 1'b0;
            access_err <= 1'b0;
        end else begin
            we_q       <= wr && access_ok;
            // Write wins the single port, so a colliding read never issues
            re_q       <= rd && !wr && access_ok;
            access_err <= drop_req;
        end
    end

    // Address and word are only captured when some request shows up
    always_ff @(posedge clk) begin
        if (any_req) begin
            addr_q <= addr;
            word_q <= {wr_par, wdata};
        end
    end

    // Parity sits in the top bits of the stored word
    assign req = '{we: we_q, re: re_q, addr: addr_q, word: word_q};

endmodule

`default_nettype wire

// ==== src/sram_pg_2048x66.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_pg_2048x66 (
     input  logic                             clk
    ,input  logic                             rst_n
    ,input  mem_store_pkg::mem_req_t          req
    ,output logic [mem_store_pkg::WORD_W-1:0] rdata
    ,output logic                             rd_fire

    // Power interface
    ,input  logic                             isol_en
    ,input  logic                             pwr_enable_b_in
    ,output logic                             pwr_enable_b_out
);

    import mem_store_pkg::*;

    // Two stage synchronizer for the internal memory reset
    logic [1:0]        mem_rst_sync;
    logic              mem_rst_n;

    // Storage array and a valid bit per entry
    logic [WORD_W-1:0] mem_array [DEPTH];
    logic [DEPTH-1:0]  entry_vld;

    // Read word before the isolation clamp
    logic [WORD_W-1:0] rdata_q;

    // ********************
    // Memory reset sync
    // ********************

    // Ones shift in after rst_n deasserts, so release lags by two edges
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rst_sync <= 2'b00;
        end else begin
            mem_rst_sync <= {mem_rst_sync[0], 1'b1};
        end
    end

    assign mem_rst_n = mem_rst_sync[1];

    // ********************
    // Power enable chain
    // ********************

    // Active low enable, so 1 means the array is powered down.
    // The array starts out powered down after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwr_enable_b_out <= 1'b1;
        end else begin
            pwr_enable_b_out <= pwr_enable_b_in;
        end
    end

    // ********************
    // Entry valid map
    // ********************

    // Contents are lost while powered down, so every entry goes invalid.
    // Clearing takes priority over a write landing in the same cycle
    always_ff @(posedge clk) begin
        if (!mem_rst_n || pwr_enable_b_out) begin
            entry_vld <= '0;
        end else if (req.we) begin
            entry_vld[req.addr] <= 1'b1;
        end
    end

    // ********************
    // Array access
    // ********************

    // Write port, the word already carries its parity bits
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem_array[req.addr] <= req.word;
        end
    end

    // Read port, entries never written since power-up read as zero
    always_ff @(posedge clk) begin
        if (req.re) begin
            if (entry_vld[req.addr]) begin
                rdata_q <= mem_array[req.addr];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // rd_fire marks the cycle in which rdata holds the fresh read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_fire <= 1'b0;
        end else begin
            rd_fire <= req.re;
        end
    end

    // Isolation clamps the read bus low
    assign rdata = isol_en ? '0 : rdata_q;

endmodule

`default_nettype wire

// ==== src/rd_data_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_data_check (
     input  logic                             clk
    ,input  logic                             rst_n
    ,input  logic [mem_store_pkg::WORD_W-1:0] rdata
    ,input  logic                             rd_fire
    ,output logic                             rsp_valid
    ,output mem_store_pkg::rd_rsp_t           rsp
);

    import mem_store_pkg::*;

    // ********************
    // Parity check
    // ********************

    logic [DATA_W-1:0] rd_data;
    logic [PAR_W-1:0]  rd_par;
    logic [PAR_W-1:0]  exp_par;
    logic              par_mismatch;

    // Registered response payload
    logic [DATA_W-1:0] data_q;
    logic              par_err_q;

    // Split the stored word back into record and parity
    assign rd_data = rdata[DATA_W-1:0];
    assign rd_par  = rdata[WORD_W-1:DATA_W];

    // Recompute parity on the record as read back
    assign exp_par = calc_par(rd_data);

    // Any half that disagrees flags the whole record
    assign par_mismatch = |(exp_par ^ rd_par);

    // ********************
    // Response register
    // ********************

    // Payload only updates on a fresh read
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            data_q    <= rd_data;
            par_err_q <= par_mismatch;
        end
    end

    // One response pulse per read, one cycle after rd_fire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_fire;
        end
    end

    assign rsp = '{data: data_q, par_err: par_err_q};

endmodule

`default_nettype wire

// ==== src/mem_store_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_store_top (
     input  logic                             clk
    ,input  logic                             rst_n

    // Client request side
    ,input  logic                             wr
    ,input  logic                             rd
    ,input  logic [mem_store_pkg::ADDR_W-1:0] addr
    ,input  logic [mem_store_pkg::DATA_W-1:0] wdata
    ,input  logic                             par_inject

    // Power interface
    ,input  logic                             isol_en
    ,input  logic                             pwr_enable_b_in
    ,output logic                             pwr_enable_b_out

    // Client response side
    ,output logic                             access_err
    ,output logic                             rsp_valid
    ,output mem_store_pkg::rd_rsp_t           rsp
);

    import mem_store_pkg::*;

    // Request into the array
    mem_req_t          req;

    // Read path from the array into the checker
    logic [WORD_W-1:0] rdata;
    logic              rd_fire;

    // ********************
    // Input side
    // ********************

    mem_req_ctrl i_mem_req_ctrl (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.addr             (addr)
        ,.wdata            (wdata)
        ,.par_inject       (par_inject)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.req              (req)
        ,.access_err       (access_err)
    );

    // ********************
    // Power-gated array
    // ********************

    sram_pg_2048x66 i_sram (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.req              (req)
        ,.rdata            (rdata)
        ,.rd_fire          (rd_fire)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ********************
    // Output side
    // ********************

    rd_data_check i_rd_data_check (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.rdata            (rdata)
        ,.rd_fire          (rd_fire)
        ,.rsp_valid        (rsp_valid)
        ,.rsp              (rsp)
    );

endmodule

`default_nettype wire

// ==== dv/mem_store_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_store_chk (
     input  logic                    clk
    ,input  logic                    rst_n
    ,input  logic                    wr
    ,input  logic                    rd
    ,input  logic                    isol_en
    ,input  logic                    pwr_enable_b_out
    ,input  logic                    access_err
    ,input  logic                    rsp_valid
    ,input  mem_store_pkg::mem_req_t req
);

    logic rd_accepted;
    logic any_req;

    // A lone read on a powered, unisolated array goes through
    assign rd_accepted = rd && !wr && !pwr_enable_b_out && !isol_en;
    assign any_req     = wr || rd;

    // ********************
    // Properties
    // ********************

    rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_accepted |-> ##3 rsp_valid)
        else $error("rsp_valid missing three cycles after an accepted read");

    // Single port, so a write and a read never issue together
    one_op_per_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        !(req.we && req.re))
        else $error("req.we and req.re set in the same cycle");

    rsp_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !rsp_valid)
        else $error("rsp_valid high while reset is held");

    err_when_powered_off: assert property (@(posedge clk) disable iff (!rst_n)
        (any_req && pwr_enable_b_out) |=> access_err)
        else $error("request while powered off did not raise access_err");

endmodule

bind mem_store_top mem_store_chk u_chk (
     .clk              (clk)
    ,.rst_n            (rst_n)
    ,.wr               (wr)
    ,.rd               (rd)
    ,.isol_en          (isol_en)
    ,.pwr_enable_b_out (pwr_enable_b_out)
    ,.access_err       (access_err)
    ,.rsp_valid        (rsp_valid)
    ,.req              (req)
);

`default_nettype wire

// ==== dv/mem_store_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_store_tb;

    import mem_store_pkg::*;

    typedef enum logic [1:0] {
        OP_IDLE = 2'd0,
        OP_WR   = 2'd1,
        OP_RD   = 2'd2,
        OP_BOTH = 2'd3
    } op_e;

    // One table row; the expected fields are filled in by the reference model
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              par_inject;
        logic              pwr_b;
        logic              isol;
        logic              exp_err;
        rd_rsp_t           exp_rsp;
    } step_t;

    localparam int CLK_HALF   = 20;
    localparam int RST_CYCLES = 4;

    logic              clk;
    logic              rst_n;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              par_inject;
    logic              isol_en;
    logic              pwr_enable_b_in;
    logic              pwr_enable_b_out;
    logic              access_err;
    logic              rsp_valid;
    rd_rsp_t           rsp;

    // Stimulus table and the responses still owed by the DUT
    step_t             tbl[$];
    rd_rsp_t           exp_q[$];
    int                due_q[$];

    // Power and isolation levels picked up by each new table row
    logic              cur_pwr_b;
    logic              cur_isol;

    // Reference model of the array contents
    logic [DATA_W-1:0] ref_rec [DEPTH];
    logic              ref_inj [DEPTH];
    logic              ref_vld [DEPTH];

    int                cycles = 0;
    int                max_cycles = 0;

    mem_store_top u_dut (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.addr             (addr)
        ,.wdata            (wdata)
        ,.par_inject       (par_inject)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.access_err       (access_err)
        ,.rsp_valid        (rsp_valid)
        ,.rsp              (rsp)
    );

    always #CLK_HALF clk = ~clk;

    // Run length guard, the limit is set once the table is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (max_cycles > 0 && cycles >= max_cycles) begin
            stop_on_error($sformatf("Timeout after %0d cycles, the table never finished",
                                    cycles));
        end
    end

    // ********************
    // Checking helpers
    // ********************

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] time %0t: %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t exp);
        if (got.data !== exp.data) begin
            stop_on_error($sformatf("[FAIL] time %0t: rsp.data is %h, expected %h",
                                    $time, got.data, exp.data));
        end
        if (got.par_err !== exp.par_err) begin
            stop_on_error($sformatf("[FAIL] time %0t: rsp.par_err is %b, expected %b",
                                    $time, got.par_err, exp.par_err));
        end
    endtask

    // ********************
    // Table construction
    // ********************

    function automatic logic [DATA_W-1:0] rand_data();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        return ADDR_W'($urandom);
    endfunction

    task automatic add_step(input op_e op, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic inj);
        step_t s;
        s            = '0;
        s.op         = op;
        s.addr       = a;
        s.data       = d;
        s.par_inject = inj;
        s.pwr_b      = cur_pwr_b;
        s.isol       = cur_isol;
        tbl.push_back(s);
    endtask

    task automatic add_idle(input int n);
        for (int k = 0; k < n; k++) begin
            add_step(OP_IDLE, '0, '0, 1'b0);
        end
    endtask

    task automatic build_table();
        logic [ADDR_W-1:0] a0;
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] pool [4];
        logic [1:0]        sel;
        logic [1:0]        psel;
        op_e               op;
        a0   = rand_addr();
        a1   = rand_addr();
        a2   = rand_addr();
        base = rand_addr();
        // Power stays off for two steps after reset, then comes up
        cur_pwr_b = 1'b1;
        cur_isol  = 1'b0;
        add_idle(2);
        cur_pwr_b = 1'b0;
        add_idle(1);
        // Read right behind a write to the same entry
        add_step(OP_WR, a0, rand_data(), 1'b0);
        add_step(OP_RD, a0, '0, 1'b0);
        add_idle(3);
        // Four writes, then four reads back to back
        for (int k = 0; k < 4; k++) begin
            add_step(OP_WR, base + ADDR_W'(k * 37), rand_data(), 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            add_step(OP_RD, base + ADDR_W'(k * 37), '0, 1'b0);
        end
        add_idle(3);
        // Corrupted parity on write must show up as par_err
        add_step(OP_WR, a1, rand_data(), 1'b1);
        add_idle(1);
        add_step(OP_RD, a1, '0, 1'b0);
        add_idle(3);
        // Collision keeps the write and drops the read
        add_step(OP_BOTH, a2, rand_data(), 1'b0);
        add_idle(1);
        add_step(OP_RD, a2, '0, 1'b0);
        add_idle(3);
        // Random traffic over a small set of entries
        for (int k = 0; k < 4; k++) begin
            pool[k] = rand_addr();
        end
        for (int k = 0; k < 16; k++) begin
            sel  = 2'($urandom % 3);
            psel = 2'($urandom);
            op   = (sel == 2'd0) ? OP_IDLE : ((sel == 2'd1) ? OP_WR : OP_RD);
            add_step(op, pool[psel], rand_data(), ($urandom % 4) == 0);
        end
        add_idle(3);
        // Power cycle, requests in between are refused and contents are lost
        cur_pwr_b = 1'b1;
        add_idle(1);
        add_step(OP_WR, a0, rand_data(), 1'b0);
        add_step(OP_RD, a1, '0, 1'b0);
        cur_pwr_b = 1'b0;
        add_idle(1);
        add_step(OP_RD, a0, '0, 1'b0);
        add_step(OP_RD, a1, '0, 1'b0);
        add_step(OP_RD, base, '0, 1'b0);
        add_idle(3);
        // A read still in flight when isolation starts comes back clamped to zero
        add_step(OP_WR, a0, rand_data(), 1'b0);
        add_step(OP_RD, a0, '0, 1'b0);
        add_idle(1);
        // Isolation refuses both kinds of request
        cur_isol = 1'b1;
        add_step(OP_WR, a2, rand_data(), 1'b0);
        add_step(OP_RD, a2, '0, 1'b0);
        cur_isol = 1'b0;
        add_idle(1);
        add_step(OP_RD, a2, '0, 1'b0);
        add_step(OP_WR, a2, rand_data(), 1'b0);
        add_step(OP_RD, a2, '0, 1'b0);
        add_idle(3);
    endtask

    // ********************
    // Reference model
    // ********************

    // Walks the table in order and fills in the error and response columns
    task automatic fill_expected();
        step_t s;
        logic  pwr_out;
        logic  ok;
        logic  clamp;
        for (int i = 0; i < tbl.size(); i++) begin
            s = tbl[i];
            // The power state seen by a request lags the input by one step
            pwr_out = (i == 0) ? 1'b1 : tbl[i-1].pwr_b;
            if (pwr_out) begin
                for (int a = 0; a < DEPTH; a++) begin
                    ref_vld[a] = 1'b0;
                end
            end
            ok        = !pwr_out && !s.isol;
            s.exp_err = (s.op != OP_IDLE) && (!ok || s.op == OP_BOTH);
            s.exp_rsp = '0;
            if (ok && (s.op == OP_WR || s.op == OP_BOTH)) begin
                ref_rec[s.addr] = s.data;
                ref_inj[s.addr] = s.par_inject;
                ref_vld[s.addr] = 1'b1;
            end
            // Read data passes the isolation clamp two steps later
            clamp = (i + 2 < tbl.size()) ? tbl[i+2].isol : 1'b0;
            if (ok && s.op == OP_RD && ref_vld[s.addr] && !clamp) begin
                s.exp_rsp.data    = ref_rec[s.addr];
                s.exp_rsp.par_err = ref_inj[s.addr];
            end
            tbl[i] = s;
        end
    endtask

    // ********************
    // Table driver
    // ********************

    task automatic check_response(input int i);
        if (due_q.size() > 0 && due_q[0] == i) begin
            if (rsp_valid !== 1'b1) begin
                stop_on_error($sformatf("No response at time %0t for the read of step %0d",
                                        $time, i - 3));
            end
            check_rsp(rsp, exp_q.pop_front());
            due_q.delete(0);
        end else if (rsp_valid !== 1'b0) begin
            stop_on_error($sformatf("Response at time %0t without a read in flight", $time));
        end
    endtask

    task automatic drive_step(input step_t s, input int i);
        wr              = (s.op == OP_WR) || (s.op == OP_BOTH);
        rd              = (s.op == OP_RD) || (s.op == OP_BOTH);
        addr            = s.addr;
        wdata           = s.data;
        par_inject      = s.par_inject;
        pwr_enable_b_in = s.pwr_b;
        isol_en         = s.isol;
        // An accepted read answers three edges later
        if (s.op == OP_RD && !s.exp_err) begin
            exp_q.push_back(s.exp_rsp);
            due_q.push_back(i + 3);
        end
    endtask

    initial begin
        void'($urandom(32'h8005));
        clk             = 1'b0;
        rst_n           = 1'b0;
        wr              = 1'b0;
        rd              = 1'b0;
        addr            = '0;
        wdata           = '0;
        par_inject      = 1'b0;
        isol_en         = 1'b0;
        pwr_enable_b_in = 1'b1;
        build_table();
        fill_expected();
        max_cycles = tbl.size() + 20;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("access_err", access_err, 1'b0);
        check_bit("pwr_enable_b_out", pwr_enable_b_out, 1'b1);
        // Outputs seen at each falling edge belong to the step driven one edge earlier
        for (int i = 0; i <= tbl.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
                check_bit("access_err", access_err, tbl[i-1].exp_err);
                check_bit("pwr_enable_b_out", pwr_enable_b_out, tbl[i-1].pwr_b);
            end
            check_response(i);
            if (i < tbl.size()) begin
                drive_step(tbl[i], i);
            end
        end
        if (exp_q.size() != 0) begin
            stop_on_error($sformatf("%0d expected responses never arrived", exp_q.size()));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/mem_store_pkg.sv
src/mem_req_ctrl.sv
src/sram_pg_2048x66.sv
src/rd_data_check.sv
src/mem_store_top.sv
dv/mem_store_chk.sv
dv/mem_store_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module mem_store_tb \
    -Mdir "$BUILD_DIR" -o mem_store_sim \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mem_store_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi
